//--- verilog/spi_pkg.sv
`default_nettype none

package spi_pkg;

    ////////////////////////////////
    // widths

    localparam int DATA_W    = 32;
    localparam int BIT_CNT_W = 7;    // counts up to 2 x DATA_W sck edges
    localparam int DIV_W     = 6;    // half-period counter
    localparam int GAP_W     = 8;    // cs to sck and sck to cs delays

    ////////////////////////////////
    // encodings

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,    // cs low, waiting before the first sck edge
        ST_SHIFT,
        ST_HOLD      // sck parked, waiting before cs goes high
    } frame_state_e;

    typedef enum logic [1:0] {WL_32, WL_16, WL_8, WL_4} word_len_e;

    typedef enum logic [1:0] {RATE_128, RATE_64, RATE_32, RATE_16} sck_rate_e;

    // bits per frame for a length code
    function automatic logic [BIT_CNT_W-1:0] word_bits(word_len_e len);
        case (len)
            WL_16:   return 7'd16;
            WL_8:    return 7'd8;
            WL_4:    return 7'd4;
            default: return 7'd32;
        endcase
    endfunction

    // gclk cycles per sck half period
    function automatic logic [DIV_W:0] half_period(sck_rate_e rate);
        case (rate)
            RATE_64: return 7'd32;
            RATE_32: return 7'd16;
            RATE_16: return 7'd8;
            default: return 7'd64;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- verilog/spi_sck_gen.sv
`timescale 1ns/1ps
`default_nettype none

module spi_sck_gen (
    input  wire logic               GCLK,
    input  wire logic               NRST,
    input  wire logic               run_i,
    input  wire logic               cpol_i,
    input  wire logic               cpha_i,
    input  wire spi_pkg::sck_rate_e rate_i,
    output logic                    sck_o,
    output logic                    sample_stb_o,
    output logic                    shift_stb_o,
    output logic                    edge_stb_o
);

    logic [spi_pkg::DIV_W:0]   hp_cycles;
    logic [spi_pkg::DIV_W-1:0] div_last;
    logic [spi_pkg::DIV_W-1:0] div_cnt;
    logic                      toggle;
    logic                      leading;

    assign hp_cycles = spi_pkg::half_period(rate_i);
    assign div_last  = hp_cycles[spi_pkg::DIV_W-1:0] - 1'b1;    // 64 wraps to 63

    ////////////////////////////////
    // divider and sck

    always_ff @(posedge GCLK) begin
        if (!NRST) begin
            div_cnt <= '0;
            sck_o   <= 1'b0;
        end else if (!run_i) begin
            div_cnt <= '0;
            sck_o   <= cpol_i;          // park at idle level
        end else if (toggle) begin
            div_cnt <= '0;
            sck_o   <= ~sck_o;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    ////////////////////////////////
    // edge strobes

    // strobes are high in the cycle before the gclk edge that flips sck,
    // so every register acting on them moves together with sck
    assign toggle  = run_i && (div_cnt == div_last);
    assign leading = (sck_o == cpol_i);    // leaving the idle level

    // cpha 0 samples on the leading edge, cpha 1 on the trailing one
    assign sample_stb_o = toggle && (leading != cpha_i);
    assign shift_stb_o  = toggle && (leading == cpha_i);
    assign edge_stb_o   = toggle;

    // sck may only move while the frame controller lets it run
    a_sck_parked: assert property (@(posedge GCLK) disable iff (!NRST)
        !run_i |=> (sck_o == $past(cpol_i)));

endmodule

`default_nettype wire

//--- verilog/spi_shift_reg.sv
`timescale 1ns/1ps
`default_nettype none

module spi_shift_reg (
    input  wire logic                       GCLK,
    input  wire logic                       NRST,
    input  wire logic                       load_stb_i,
    input  wire logic                       sample_stb_i,
    input  wire logic                       shift_stb_i,
    input  wire logic                       cpha_i,
    input  wire spi_pkg::word_len_e         len_i,
    input  wire logic [spi_pkg::DATA_W-1:0] tx_word_i,
    input  wire logic                       miso_i,
    output logic                            mosi_o,
    output logic [spi_pkg::DATA_W-1:0]      rx_word_o
);

    logic [spi_pkg::BIT_CNT_W-1:0] nbits;
    logic [spi_pkg::DATA_W-1:0]    tx_aligned;
    logic [spi_pkg::DATA_W-1:0]    rx_mask;
    logic [spi_pkg::DATA_W-1:0]    tx_q;
    logic [spi_pkg::DATA_W-1:0]    rx_q;
    logic [spi_pkg::DATA_W-1:0]    rx_nxt;

    assign nbits      = spi_pkg::word_bits(len_i);
    assign tx_aligned = tx_word_i << (spi_pkg::DATA_W - nbits);    // word msb at the top
    assign rx_mask    = {spi_pkg::DATA_W{1'b1}} >> (spi_pkg::DATA_W - nbits);

    ////////////////////////////////
    // transmit

    always_ff @(posedge GCLK) begin
        if (!NRST) begin
            mosi_o <= 1'b0;
        end else if (load_stb_i) begin
            if (!cpha_i) begin
                mosi_o <= tx_aligned[spi_pkg::DATA_W-1];    // first bit with cs
            end
        end else if (shift_stb_i) begin
            mosi_o <= tx_q[spi_pkg::DATA_W-1];
        end
    end

    always_ff @(posedge GCLK) begin
        if (load_stb_i) begin
            tx_q <= cpha_i ? tx_aligned : (tx_aligned << 1);
        end else if (shift_stb_i) begin
            tx_q <= tx_q << 1;
        end
    end

    ////////////////////////////////
    // receive

    always_comb begin
        rx_nxt = rx_q;
        if (load_stb_i) begin
            rx_nxt = '0;
        end else if (sample_stb_i) begin
            rx_nxt = {rx_q[spi_pkg::DATA_W-2:0], miso_i} & rx_mask;
        end
    end

    always_ff @(posedge GCLK) begin
        rx_q <= rx_nxt;
    end

    // next value, so a sample on the last sck edge is already visible
    assign rx_word_o = rx_nxt;

    a_stb_excl: assert property (@(posedge GCLK) disable iff (!NRST)
        !(sample_stb_i && shift_stb_i));

    // a word is only loaded while sck is parked
    a_load_quiet: assert property (@(posedge GCLK) disable iff (!NRST)
        load_stb_i |-> !(sample_stb_i || shift_stb_i));

endmodule

`default_nettype wire

//--- verilog/spi_frame_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module spi_frame_ctrl (
    input  wire logic                       GCLK,
    input  wire logic                       NRST,
    input  wire logic                       start_i,
    input  wire spi_pkg::word_len_e         len_i,
    input  wire logic [spi_pkg::GAP_W-1:0]  cs_sck_i,
    input  wire logic [spi_pkg::GAP_W-1:0]  sck_cs_i,
    input  wire logic                       edge_stb_i,
    input  wire logic [spi_pkg::DATA_W-1:0] rx_word_i,
    output logic                            sck_run_o,
    output logic                            load_stb_o,
    output logic                            cs_o,
    output logic                            busy_o,
    output logic [spi_pkg::DATA_W-1:0]      miso_data_o
);

    spi_pkg::frame_state_e         state;
    logic                          start_d;
    logic                          start_pls;
    logic [spi_pkg::GAP_W-1:0]     gap_cnt;
    logic [spi_pkg::BIT_CNT_W-1:0] edge_cnt;
    logic [spi_pkg::BIT_CNT_W-1:0] edge_total;
    logic                          last_edge;
    logic                          setup_done;
    logic                          hold_done;
    logic                          frame_end;

    assign edge_total = spi_pkg::word_bits(len_i) << 1;    // two sck edges per bit
    assign last_edge  = edge_stb_i && (edge_cnt == edge_total - 1'b1);
    assign setup_done = (gap_cnt == cs_sck_i - 1'b1);
    assign hold_done  = (gap_cnt == sck_cs_i - 1'b1);

    assign sck_run_o  = (state == spi_pkg::ST_SHIFT);
    assign load_stb_o = (state == spi_pkg::ST_IDLE) && start_pls;
    assign frame_end  = ((state == spi_pkg::ST_SHIFT) && last_edge && (sck_cs_i == '0))
                     || ((state == spi_pkg::ST_HOLD) && hold_done);

    // start edge registered once more so cs falls one cycle after it is seen
    always_ff @(posedge GCLK) begin
        if (!NRST) begin
            start_d   <= 1'b0;
            start_pls <= 1'b0;
        end else begin
            start_d   <= start_i;
            start_pls <= start_i && !start_d;
        end
    end

    ////////////////////////////////
    // frame fsm

    always_ff @(posedge GCLK) begin
        if (!NRST) begin
            state    <= spi_pkg::ST_IDLE;
            gap_cnt  <= '0;
            edge_cnt <= '0;
        end else begin
            case (state)
                spi_pkg::ST_IDLE: begin
                    gap_cnt  <= '0;
                    edge_cnt <= '0;
                    if (start_pls) begin
                        state <= (cs_sck_i == '0) ? spi_pkg::ST_SHIFT : spi_pkg::ST_SETUP;
                    end
                end
                spi_pkg::ST_SETUP: begin
                    if (setup_done) begin
                        state <= spi_pkg::ST_SHIFT;
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
                spi_pkg::ST_SHIFT: begin
                    gap_cnt <= '0;
                    if (edge_stb_i) begin
                        edge_cnt <= edge_cnt + 1'b1;
                    end
                    if (last_edge) begin    // sck run drops with the last toggle
                        state <= (sck_cs_i == '0) ? spi_pkg::ST_IDLE : spi_pkg::ST_HOLD;
                    end
                end
                spi_pkg::ST_HOLD: begin
                    if (hold_done) begin
                        state <= spi_pkg::ST_IDLE;
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
                default: state <= spi_pkg::ST_IDLE;
            endcase
        end
    end

    ////////////////////////////////
    // chip select, busy and result

    always_ff @(posedge GCLK) begin
        if (!NRST) begin
            cs_o        <= 1'b1;
            busy_o      <= 1'b0;
            miso_data_o <= '0;
        end else if (load_stb_o) begin
            cs_o   <= 1'b0;
            busy_o <= 1'b1;
        end else if (frame_end) begin
            cs_o        <= 1'b1;
            busy_o      <= 1'b0;
            miso_data_o <= rx_word_i;    // held until the next frame ends
        end
    end

    a_cs_busy: assert property (@(posedge GCLK) disable iff (!NRST)
        cs_o == !busy_o);

endmodule

`default_nettype wire

//--- verilog/spi_master.sv
`timescale 1ns/1ps
`default_nettype none

module spi_master (
    input  wire logic                       GCLK,
    input  wire logic                       NRST,
    input  wire logic                       start_i,
    input  wire logic [1:0]                 spi_mode_i,     // {cpol, cpha}
    input  wire logic [1:0]                 sck_speed_i,
    input  wire logic [1:0]                 word_len_i,
    input  wire logic [spi_pkg::GAP_W-1:0]  cs_sck_i,
    input  wire logic [spi_pkg::GAP_W-1:0]  sck_cs_i,
    input  wire logic [spi_pkg::DATA_W-1:0] mosi_data_i,
    input  wire logic                       miso_i,
    output wire logic                       busy_o,
    output wire logic [spi_pkg::DATA_W-1:0] miso_data_o,
    output wire logic                       mosi_o,
    output wire logic                       sclk_o,
    output wire logic                       cs_o
);

    wire logic                       sck_run;
    wire logic                       sample_stb;
    wire logic                       shift_stb;
    wire logic                       edge_stb;
    wire logic                       load_stb;
    wire logic [spi_pkg::DATA_W-1:0] rx_word;

    spi_sck_gen u_sck_gen (
        .GCLK         (GCLK),
        .NRST         (NRST),
        .run_i        (sck_run),
        .cpol_i       (spi_mode_i[1]),
        .cpha_i       (spi_mode_i[0]),
        .rate_i       (spi_pkg::sck_rate_e'(sck_speed_i)),
        .sck_o        (sclk_o),
        .sample_stb_o (sample_stb),
        .shift_stb_o  (shift_stb),
        .edge_stb_o   (edge_stb)
    );

    spi_shift_reg u_shift_reg (
        .GCLK         (GCLK),
        .NRST         (NRST),
        .load_stb_i   (load_stb),
        .sample_stb_i (sample_stb),
        .shift_stb_i  (shift_stb),
        .cpha_i       (spi_mode_i[0]),
        .len_i        (spi_pkg::word_len_e'(word_len_i)),
        .tx_word_i    (mosi_data_i),
        .miso_i       (miso_i),
        .mosi_o       (mosi_o),
        .rx_word_o    (rx_word)
    );

    spi_frame_ctrl u_frame_ctrl (
        .GCLK         (GCLK),
        .NRST         (NRST),
        .start_i      (start_i),
        .len_i        (spi_pkg::word_len_e'(word_len_i)),
        .cs_sck_i     (cs_sck_i),
        .sck_cs_i     (sck_cs_i),
        .edge_stb_i   (edge_stb),
        .rx_word_i    (rx_word),
        .sck_run_o    (sck_run),
        .load_stb_o   (load_stb),
        .cs_o         (cs_o),
        .busy_o       (busy_o),
        .miso_data_o  (miso_data_o)
    );

endmodule

`default_nettype wire

//--- dv/spi_master_tb.sv
`timescale 1ns/1ps
`default_nettype none

module spi_master_tb;

    localparam logic [31:0] LFSR_SEED  = 32'hc690;
    localparam int          NUM_FRAMES = 40;
    localparam int          RISE_LIMIT = 8;       // gclk cycles from start_i to busy_o
    localparam int          FALL_LIMIT = 6000;    // longest frame is 4096 cycles plus delays

    logic        GCLK = 1'b0;
    logic        NRST;
    logic        start_i;
    logic [1:0]  spi_mode_i;
    logic [1:0]  sck_speed_i;
    logic [1:0]  word_len_i;
    logic [7:0]  cs_sck_i;
    logic [7:0]  sck_cs_i;
    logic [31:0] mosi_data_i;
    logic        miso_i = 1'b0;
    logic        busy_o;
    logic [31:0] miso_data_o;
    logic        mosi_o;
    logic        sclk_o;
    logic        cs_o;

    logic [31:0] lfsr_q;
    logic [31:0] slave_word;          // slave reply sent msb first on miso
    logic [31:0] slave_rx = '0;       // bits the slave saw on mosi
    int          tx_idx = 0;
    bit          in_frame = 1'b0;
    logic        prev_cs = 1'b1;
    logic        prev_sclk = 1'b0;
    logic        prev_cpol = 1'b0;
    int          cyc = 0;
    int          fall_cyc = 0;
    int          last_tog = 0;
    int          tog_cnt = 0;
    int          frames_seen = 0;

    spi_master u_spi_master (
        .GCLK        (GCLK),
        .NRST        (NRST),
        .start_i     (start_i),
        .spi_mode_i  (spi_mode_i),
        .sck_speed_i (sck_speed_i),
        .word_len_i  (word_len_i),
        .cs_sck_i    (cs_sck_i),
        .sck_cs_i    (sck_cs_i),
        .mosi_data_i (mosi_data_i),
        .miso_i      (miso_i),
        .busy_o      (busy_o),
        .miso_data_o (miso_data_o),
        .mosi_o      (mosi_o),
        .sclk_o      (sclk_o),
        .cs_o        (cs_o)
    );

    always #5 GCLK = ~GCLK;

    //////////////////////////////
    // helpers

    // galois lfsr stepped once per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        out_bit;
        val = '0;
        for (int i = 0; i < n; i++) begin
            out_bit = lfsr_q[0];
            lfsr_q  = {1'b0, lfsr_q[31:1]} ^ (out_bit ? 32'h8020_0003 : 32'h0);
            val     = {val[30:0], out_bit};
        end
        return val;
    endfunction

    function automatic int frame_bits(input logic [1:0] len);
        return 32 >> len;    // 32, 16, 8, 4
    endfunction

    function automatic int half_cycles(input logic [1:0] rate);
        return 64 >> rate;    // 64, 32, 16, 8
    endfunction

    function automatic logic [31:0] word_mask(input logic [1:0] len);
        logic [63:0] ones;
        ones = (64'd1 << frame_bits(len)) - 64'd1;
        return ones[31:0];
    endfunction

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            abort_run();
        end
    endtask

    //////////////////////////////
    // slave model and timing monitor

    // reads the values settled after the previous edge
    always @(posedge GCLK) begin : monitor
        logic leading;
        cyc = cyc + 1;
        if (NRST) begin
            check_val("cs_o vs busy_o", 32'(cs_o), 32'(!busy_o));
            if (!in_frame && prev_cs && !cs_o) begin    // chip select fell
                in_frame = 1'b1;
                frames_seen = frames_seen + 1;
                fall_cyc = cyc;
                tog_cnt = 0;
                slave_rx = '0;
                tx_idx = frame_bits(word_len_i) - 1;
                if (!spi_mode_i[0]) begin
                    miso_i <= slave_word[tx_idx];    // first bit goes out with cs
                    tx_idx = tx_idx - 1;
                end
            end
            if (in_frame && (sclk_o !== prev_sclk)) begin
                if (tog_cnt == 0) begin
                    check_val("sclk_o first toggle delay", cyc - fall_cyc,
                              cs_sck_i + half_cycles(sck_speed_i));
                end else begin
                    check_val("sclk_o half period", cyc - last_tog, half_cycles(sck_speed_i));
                end
                last_tog = cyc;
                tog_cnt = tog_cnt + 1;
                leading = (prev_sclk == spi_mode_i[1]);
                if (leading != spi_mode_i[0]) begin
                    slave_rx = {slave_rx[30:0], mosi_o};    // sample edge
                end else if (tx_idx >= 0) begin
                    miso_i <= slave_word[tx_idx];
                    tx_idx = tx_idx - 1;
                end
            end else if (in_frame && tog_cnt == 0) begin
                check_val("sclk_o before first toggle", 32'(sclk_o), 32'(spi_mode_i[1]));
            end
            if (in_frame && cs_o) begin    // chip select rose
                in_frame = 1'b0;
                check_val("sclk_o toggle count", tog_cnt, 2 * frame_bits(word_len_i));
                check_val("cs_o hold delay", cyc - last_tog, 32'(sck_cs_i));
                check_val("mosi_o word", slave_rx, mosi_data_i & word_mask(word_len_i));
                check_val("miso_data_o", miso_data_o, slave_word & word_mask(word_len_i));
            end
            if (!in_frame) begin
                check_val("sclk_o while idle", 32'(sclk_o), 32'(prev_cpol));
            end
        end
        prev_cs = cs_o;
        prev_sclk = sclk_o;
        prev_cpol = spi_mode_i[1];
    end

    //////////////////////////////
    // stimulus

    initial begin
        int n;
        int waited;
        lfsr_q = LFSR_SEED;
        NRST <= 1'b0;
        start_i <= 1'b0;
        spi_mode_i <= 2'b00;
        sck_speed_i <= 2'b00;
        word_len_i <= 2'b00;
        cs_sck_i <= '0;
        sck_cs_i <= '0;
        mosi_data_i <= '0;
        slave_word <= '0;
        repeat (4) @(posedge GCLK);
        NRST <= 1'b1;
        repeat (2) @(posedge GCLK);
        check_val("cs_o after reset", 32'(cs_o), 32'd1);
        check_val("busy_o after reset", 32'(busy_o), 32'd0);
        check_val("miso_data_o after reset", miso_data_o, 32'd0);
        check_val("sclk_o after reset", 32'(sclk_o), 32'd0);

        for (n = 0; n < NUM_FRAMES; n++) begin
            @(posedge GCLK);
            if (n < 16) begin    // sweep every mode, length and speed first
                spi_mode_i <= n[1:0];
                word_len_i <= n[3:2];
                sck_speed_i <= n[1:0] + n[3:2];
            end else begin
                spi_mode_i <= 2'(rand_bits(2));
                word_len_i <= 2'(rand_bits(2));
                sck_speed_i <= 2'(rand_bits(2));
            end
            cs_sck_i <= 8'(rand_bits(4));
            sck_cs_i <= 8'(rand_bits(4));
            mosi_data_i <= rand_bits(32);
            slave_word <= rand_bits(32);
            repeat (2) @(posedge GCLK);
            start_i <= 1'b1;
            waited = 0;
            while (busy_o !== 1'b1) begin
                if (waited == RISE_LIMIT) begin
                    $display("Timeout: busy_o did not rise after a start_i edge");
                    abort_run();
                end
                @(posedge GCLK);
                waited++;
            end
            start_i <= 1'b0;
            @(posedge GCLK);
            start_i <= 1'b1;    // second edge while busy must start no new frame
            @(posedge GCLK);
            start_i <= 1'b0;
            waited = 0;
            while (busy_o !== 1'b0) begin
                if (waited == FALL_LIMIT) begin
                    $display("Timeout: busy_o did not fall, the frame never ended");
                    abort_run();
                end
                @(posedge GCLK);
                waited++;
            end
            repeat (4) begin
                @(posedge GCLK);
                check_val("busy_o after frame end", 32'(busy_o), 32'd0);
            end
        end

        check_val("frames started", frames_seen, NUM_FRAMES);
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- spi_master.f
verilog/spi_pkg.sv
verilog/spi_sck_gen.sv
verilog/spi_shift_reg.sv
verilog/spi_frame_ctrl.sv
verilog/spi_master.sv
dv/spi_master_tb.sv

//--- Makefile
SIM  := obj_dir/Vspi_master_tb
SRCS := $(wildcard verilog/*.sv dv/*.sv)

.PHONY: all run clean

all: run

$(SIM): spi_master.f $(SRCS)
	verilator --binary --assert --timescale 1ns/1ps --top-module spi_master_tb \
		-Mdir obj_dir -f spi_master.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Errors found" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "No errors" sim.log; then echo "simulation did not complete"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log
